//--- rtl/rename_pkg.sv
// rename unit types; FREE_DEPTH and ROB_DEPTH must be powers of two, tags above NUM_AREGS start free
package rename_pkg;

	// ====================
	// sizes
	// ====================
	localparam int NUM_AREGS	= 32;	// architectural regs
	localparam int NUM_PREGS	= 40;	// physical regs
	localparam int FREE_DEPTH	= 8;	// NUM_PREGS - NUM_AREGS, free after reset
	localparam int ROB_DEPTH	= 16;
	localparam int ZERO_REG		= 31;	// hard-wired zero, never renamed

	// ====================
	// index types
	// ====================
	typedef logic [$clog2(NUM_AREGS)-1:0]	areg_idx_t;
	typedef logic [$clog2(NUM_PREGS)-1:0]	preg_idx_t;
	typedef logic [$clog2(ROB_DEPTH)-1:0]	rob_idx_t;

	// queue pointers and occupancy counts
	typedef logic [$clog2(FREE_DEPTH)-1:0]	free_ptr_t;
	typedef logic [$clog2(FREE_DEPTH):0]	free_cnt_t;	// one extra bit, holds FREE_DEPTH
	typedef logic [$clog2(ROB_DEPTH):0]		rob_cnt_t;

	// ====================
	// interface structs
	// ====================
	typedef struct packed {
		logic		valid;
		areg_idx_t	dest_areg;	// ZERO_REG means no destination
		areg_idx_t	opa_areg;
		areg_idx_t	opb_areg;
	} disp_req_t;

	typedef struct packed {
		preg_idx_t	opa_preg;
		logic		opa_rdy;
		preg_idx_t	opb_preg;
		logic		opb_rdy;
		preg_idx_t	dest_preg;	// zero when has_dest is low
		logic		has_dest;
		rob_idx_t	rob_idx;
	} rename_rsp_t;

	typedef struct packed {
		logic		valid;		// single-cycle pulse
		rob_idx_t	rob_idx;
	} complete_t;

	typedef struct packed {
		logic		valid;
		areg_idx_t	areg;
		preg_idx_t	new_preg;
		preg_idx_t	old_preg;	// goes back to the free list
		logic		has_dest;
	} retire_t;

endpackage : rename_pkg

//--- rtl/map_table.sv
// rename map; reads are combinational, a ready-set and an allocate never hit the same tag in one cycle
module map_table (
	input	logic					clk,
	input	logic					rst_n_i,

	input	rename_pkg::disp_req_t	disp_req_i,
	input	logic					disp_en_i,		// accepted dispatch
	input	rename_pkg::preg_idx_t	alloc_preg_i,	// free list head
	input	logic					set_rdy_en_i,	// from ROB on completion
	input	rename_pkg::preg_idx_t	set_rdy_preg_i,

	output	rename_pkg::preg_idx_t	opa_preg_o,
	output	rename_pkg::preg_idx_t	opb_preg_o,
	output	rename_pkg::preg_idx_t	old_preg_o,		// previous tag of dest, for ROB
	output	logic					opa_rdy_o,
	output	logic					opb_rdy_o
);
	import rename_pkg::*;

	preg_idx_t				map_q [NUM_AREGS];	// areg -> current tag
	logic [NUM_PREGS-1:0]	rdy_q;				// one bit per physical reg

	logic					has_dest;
	logic					opa_zero;
	logic					opb_zero;

	assign has_dest	= (disp_req_i.dest_areg != areg_idx_t'(ZERO_REG));
	assign opa_zero	= (disp_req_i.opa_areg == areg_idx_t'(ZERO_REG));
	assign opb_zero	= (disp_req_i.opb_areg == areg_idx_t'(ZERO_REG));

	// ====================
	// read ports
	// ====================
	// zero reg always reads as its own tag, ready
	assign opa_preg_o	= opa_zero ? preg_idx_t'(ZERO_REG) : map_q[disp_req_i.opa_areg];
	assign opb_preg_o	= opb_zero ? preg_idx_t'(ZERO_REG) : map_q[disp_req_i.opb_areg];
	assign opa_rdy_o	= opa_zero | rdy_q[map_q[disp_req_i.opa_areg]];
	assign opb_rdy_o	= opb_zero | rdy_q[map_q[disp_req_i.opb_areg]];
	assign old_preg_o	= map_q[disp_req_i.dest_areg];

	// ====================
	// update
	// ====================
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_AREGS; i++) begin
				map_q[i] <= preg_idx_t'(i);	// identity map
			end
			rdy_q <= '1;	// every committed value is there
		end else begin
			if (set_rdy_en_i) begin
				rdy_q[set_rdy_preg_i] <= 1'b1;	// result produced
			end
			if (disp_en_i && has_dest) begin
				map_q[disp_req_i.dest_areg]	<= alloc_preg_i;
				rdy_q[alloc_preg_i]			<= 1'b0;	// new tag pending until completion
			end
		end
	end

	// tag 31 stays with the zero reg and never comes back from the free list
	a_zero_reg_fixed: assert property (@(posedge clk) disable iff (!rst_n_i)
		(disp_en_i && has_dest) |-> (alloc_preg_i != preg_idx_t'(ZERO_REG)))
		else $error("zero register tag handed out as a new tag");

endmodule : map_table

//--- rtl/free_list.sv
// free tag FIFO; no same-cycle bypass, a pushed tag is poppable from the next cycle on
module free_list (
	input	logic					clk,
	input	logic					rst_n_i,

	input	logic					pop_i,			// dispatch with a destination
	input	logic					push_i,			// retire with a destination
	input	rename_pkg::preg_idx_t	push_preg_i,	// old tag of the retiring entry

	output	rename_pkg::preg_idx_t	head_preg_o,	// next tag to hand out
	output	logic					empty_o
);
	import rename_pkg::*;

	preg_idx_t	fifo_q [FREE_DEPTH];
	free_ptr_t	head_q;
	free_ptr_t	tail_q;
	free_cnt_t	count_q;

	assign head_preg_o	= fifo_q[head_q];
	assign empty_o		= (count_q == '0);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			// tags 32..39 start free, queue full
			for (int i = 0; i < FREE_DEPTH; i++) begin
				fifo_q[i] <= preg_idx_t'(NUM_AREGS + i);
			end
			head_q	<= '0;
			tail_q	<= '0;	// wrapped onto head
			count_q	<= free_cnt_t'(FREE_DEPTH);
		end else begin
			if (pop_i) begin
				head_q <= head_q + 1'b1;	// power-of-two wrap
			end
			if (push_i) begin
				fifo_q[tail_q]	<= push_preg_i;
				tail_q			<= tail_q + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10:		count_q <= count_q + 1'b1;
				2'b01:		count_q <= count_q - 1'b1;
				default:	count_q <= count_q;	// both or neither
			endcase
		end
	end

	// ====================
	// checks
	// ====================
	// dispatch gate in the top level must hold these
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
		pop_i |-> !empty_o)
		else $error("free list popped while empty");

	// 40 tags total, so a push into a full list means a tag got duplicated
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n_i)
		push_i |-> (count_q != free_cnt_t'(FREE_DEPTH)))
		else $error("free list pushed while full");

endmodule : free_list

//--- rtl/reorder_buffer.sv
// in-order ROB, one dispatch and one retire per cycle; completion for an empty or done slot is illegal
module reorder_buffer (
	input	logic					clk,
	input	logic					rst_n_i,

	// dispatch, written at the tail
	input	logic					disp_en_i,
	input	rename_pkg::areg_idx_t	disp_areg_i,
	input	logic					has_dest_i,
	input	rename_pkg::preg_idx_t	new_preg_i,
	input	rename_pkg::preg_idx_t	old_preg_i,

	input	rename_pkg::complete_t	complete_i,

	output	rename_pkg::rob_idx_t	tail_idx_o,		// slot the next dispatch gets
	output	logic					full_o,
	output	logic					set_rdy_en_o,	// to map table ready bits
	output	rename_pkg::preg_idx_t	set_rdy_preg_o,
	output	rename_pkg::retire_t	retire_o
);
	import rename_pkg::*;

	// ====================
	// storage
	// ====================
	// payload per slot, written at dispatch
	areg_idx_t				areg_q [ROB_DEPTH];
	preg_idx_t				new_q [ROB_DEPTH];
	preg_idx_t				old_q [ROB_DEPTH];
	logic [ROB_DEPTH-1:0]	has_dest_q;

	// control
	logic [ROB_DEPTH-1:0]	done_q;
	rob_idx_t				head_q;
	rob_idx_t				tail_q;
	rob_cnt_t				count_q;

	logic					retire_en;
	rob_idx_t				comp_off;	// completion slot relative to head
	logic					comp_live;

	assign tail_idx_o	= tail_q;
	assign full_o		= (count_q == rob_cnt_t'(ROB_DEPTH));

	// ====================
	// completion
	// ====================
	// echo the stored tag so the map can flag it ready
	assign set_rdy_en_o		= complete_i.valid && has_dest_q[complete_i.rob_idx];
	assign set_rdy_preg_o	= new_q[complete_i.rob_idx];

	assign comp_off		= complete_i.rob_idx - head_q;	// wraps mod ROB_DEPTH
	assign comp_live	= ({1'b0, comp_off} < count_q);

	// ====================
	// retirement
	// ====================
	assign retire_en			= (count_q != '0) && done_q[head_q];
	assign retire_o.valid		= retire_en;
	assign retire_o.areg		= areg_q[head_q];
	assign retire_o.new_preg	= new_q[head_q];
	assign retire_o.old_preg	= old_q[head_q];
	assign retire_o.has_dest	= has_dest_q[head_q];

	always_ff @(posedge clk) begin
		if (disp_en_i) begin
			areg_q[tail_q]		<= disp_areg_i;
			new_q[tail_q]		<= new_preg_i;
			old_q[tail_q]		<= old_preg_i;
			has_dest_q[tail_q]	<= has_dest_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			done_q	<= '0;
			head_q	<= '0;
			tail_q	<= '0;
			count_q	<= '0;
		end else begin
			if (complete_i.valid) begin
				done_q[complete_i.rob_idx] <= 1'b1;
			end
			if (disp_en_i) begin
				done_q[tail_q]	<= 1'b0;	// never the completing slot, it is not live yet
				tail_q			<= tail_q + 1'b1;
			end
			if (retire_en) begin
				head_q <= head_q + 1'b1;
			end
			case ({disp_en_i, retire_en})
				2'b10:		count_q <= count_q + 1'b1;
				2'b01:		count_q <= count_q - 1'b1;
				default:	count_q <= count_q;
			endcase
		end
	end

	// function units may only finish what was dispatched and still waits
	a_complete_live: assert property (@(posedge clk) disable iff (!rst_n_i)
		complete_i.valid |-> (comp_live && !done_q[complete_i.rob_idx]))
		else $error("completion names an empty or already done ROB slot");

endmodule : reorder_buffer

//--- rtl/rename_core.sv
// rename top; accept and response are combinational, no free-list bypass from a same-cycle retire
module rename_core (
	input	logic						clk,
	input	logic						rst_n_i,

	input	rename_pkg::disp_req_t		disp_req_i,
	input	rename_pkg::complete_t		complete_i,

	output	logic						disp_accept_o,
	output	rename_pkg::rename_rsp_t	rename_o,
	output	rename_pkg::retire_t		retire_o
);
	import rename_pkg::*;

	logic		has_dest;
	logic		fl_pop;
	logic		fl_empty;
	preg_idx_t	fl_head_preg;
	preg_idx_t	new_preg;
	preg_idx_t	old_preg;
	preg_idx_t	opa_preg;
	preg_idx_t	opb_preg;
	logic		opa_rdy;
	logic		opb_rdy;
	logic		rob_full;
	rob_idx_t	rob_tail;
	logic		set_rdy_en;
	preg_idx_t	set_rdy_preg;
	retire_t	retire;

	// ====================
	// dispatch gate
	// ====================
	assign has_dest			= (disp_req_i.dest_areg != areg_idx_t'(ZERO_REG));
	// zero-reg dest needs no tag, so an empty free list does not stall it
	assign disp_accept_o	= disp_req_i.valid && !rob_full && (!fl_empty || !has_dest);
	assign fl_pop			= disp_accept_o && has_dest;
	assign new_preg			= has_dest ? fl_head_preg : '0;

	// response to the issue side
	assign rename_o.opa_preg	= opa_preg;
	assign rename_o.opa_rdy		= opa_rdy;
	assign rename_o.opb_preg	= opb_preg;
	assign rename_o.opb_rdy		= opb_rdy;
	assign rename_o.dest_preg	= new_preg;
	assign rename_o.has_dest	= has_dest;
	assign rename_o.rob_idx		= rob_tail;

	assign retire_o = retire;

	map_table map_table0 (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.disp_req_i		(disp_req_i),
		.disp_en_i		(disp_accept_o),
		.alloc_preg_i	(fl_head_preg),
		.set_rdy_en_i	(set_rdy_en),
		.set_rdy_preg_i	(set_rdy_preg),
		.opa_preg_o		(opa_preg),
		.opb_preg_o		(opb_preg),
		.old_preg_o		(old_preg),
		.opa_rdy_o		(opa_rdy),
		.opb_rdy_o		(opb_rdy)
	);

	free_list free_list0 (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.pop_i			(fl_pop),
		.push_i			(retire.valid && retire.has_dest),	// old tag freed at retire
		.push_preg_i	(retire.old_preg),
		.head_preg_o	(fl_head_preg),
		.empty_o		(fl_empty)
	);

	reorder_buffer rob0 (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.disp_en_i		(disp_accept_o),
		.disp_areg_i	(disp_req_i.dest_areg),
		.has_dest_i		(has_dest),
		.new_preg_i		(new_preg),
		.old_preg_i		(old_preg),	// tag 31 for a zero-reg dest, never pushed
		.complete_i		(complete_i),
		.tail_idx_o		(rob_tail),
		.full_o			(rob_full),
		.set_rdy_en_o	(set_rdy_en),
		.set_rdy_preg_o	(set_rdy_preg),
		.retire_o		(retire)
	);

endmodule : rename_core

//--- tb/rename_checker.sv
// reference model of the rename core; samples at the rising edge, inputs must settle before it
module rename_checker (
	input	logic						clk,
	input	logic						rst_n_i,
	input	logic						check_en_i,		// a table row is on the inputs
	input	int							test_i,
	input	logic						exp_accept_i,	// from the table
	input	logic						exp_retire_i,
	input	rename_pkg::disp_req_t		disp_req_i,
	input	rename_pkg::complete_t		complete_i,
	input	logic						accept_i,		// DUT outputs from here on
	input	rename_pkg::rename_rsp_t	rename_i,
	input	rename_pkg::retire_t		retire_i,
	output	int							tests_ok_o,
	output	int							tests_bad_o,
	output	int							errors_o
);
	timeunit 1ns;
	timeprecision 100ps;
	import rename_pkg::*;

	// ====================
	// model state
	// ====================
	preg_idx_t				map_m [NUM_AREGS];
	logic [NUM_PREGS-1:0]	rdy_m;
	preg_idx_t				free_m [$];		// free tags, oldest first
	areg_idx_t				r_areg [ROB_DEPTH];
	preg_idx_t				r_new [ROB_DEPTH];
	preg_idx_t				r_old [ROB_DEPTH];
	logic [ROB_DEPTH-1:0]	r_dest;
	logic [ROB_DEPTH-1:0]	r_done;
	int						rob_head;
	int						rob_cnt;
	int						cur_test;		// 0 while no test runs
	int						test_errs;

	task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t: test %0d %s is %0d, expected %0d", $time, cur_test, what, got, exp);
			errors_o++;
			test_errs++;
		end
	endtask

	task automatic close_test();
		if (test_errs == 0) begin
			$display("test %0d ok", cur_test);
			tests_ok_o++;
		end else begin
			$display("test %0d failed with %0d mismatches", cur_test, test_errs);
			tests_bad_o++;
		end
		test_errs = 0;
	endtask

	// zero reg reads as tag 31 whatever the map holds
	function automatic preg_idx_t read_tag(input areg_idx_t a);
		return (a == areg_idx_t'(ZERO_REG)) ? preg_idx_t'(ZERO_REG) : map_m[a];
	endfunction

	always @(posedge clk) begin
		logic		has_dest;
		logic		exp_acc;
		logic		exp_ret;
		preg_idx_t	new_tag;
		int			tail;
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_AREGS; i++) begin
				map_m[i] = preg_idx_t'(i);
			end
			rdy_m = '1;
			free_m.delete();
			for (int i = 0; i < FREE_DEPTH; i++) begin
				free_m.push_back(preg_idx_t'(NUM_AREGS + i));	// 32..39
			end
			r_done = '0;
			rob_head = 0;
			rob_cnt = 0;
			cur_test = 0;
			test_errs = 0;
			tests_ok_o = 0;
			tests_bad_o = 0;
			errors_o = 0;
		end else if (check_en_i) begin
			if (test_i != cur_test) begin
				if (cur_test != 0) begin
					close_test();
				end
				cur_test = test_i;
			end
			has_dest = (disp_req_i.dest_areg != areg_idx_t'(ZERO_REG));
			exp_acc = disp_req_i.valid && (rob_cnt < ROB_DEPTH) && (free_m.size() > 0 || !has_dest);
			exp_ret = (rob_cnt > 0) && r_done[rob_head];	// head done in an earlier cycle
			tail = (rob_head + rob_cnt) % ROB_DEPTH;
			expect_eq("accept vs model", accept_i, exp_acc);
			expect_eq("accept vs table", accept_i, exp_accept_i);
			expect_eq("retire valid vs model", retire_i.valid, exp_ret);
			expect_eq("retire valid vs table", retire_i.valid, exp_retire_i);
			if (exp_acc) begin
				new_tag = has_dest ? free_m[0] : '0;
				expect_eq("opa tag", rename_i.opa_preg, read_tag(disp_req_i.opa_areg));
				expect_eq("opa ready", rename_i.opa_rdy, rdy_m[read_tag(disp_req_i.opa_areg)]);
				expect_eq("opb tag", rename_i.opb_preg, read_tag(disp_req_i.opb_areg));
				expect_eq("opb ready", rename_i.opb_rdy, rdy_m[read_tag(disp_req_i.opb_areg)]);
				expect_eq("dest tag", rename_i.dest_preg, new_tag);
				expect_eq("has_dest", rename_i.has_dest, has_dest);
				expect_eq("rob index", rename_i.rob_idx, tail);
			end
			if (exp_ret) begin
				expect_eq("retire areg", retire_i.areg, r_areg[rob_head]);
				expect_eq("retire new tag", retire_i.new_preg, r_new[rob_head]);
				expect_eq("retire old tag", retire_i.old_preg, r_old[rob_head]);
				expect_eq("retire has_dest", retire_i.has_dest, r_dest[rob_head]);
			end
			// ====================
			// model update at this edge
			// ====================
			if (complete_i.valid) begin
				r_done[complete_i.rob_idx] = 1'b1;
				if (r_dest[complete_i.rob_idx]) begin
					rdy_m[r_new[complete_i.rob_idx]] = 1'b1;
				end
			end
			if (exp_acc) begin
				r_areg[tail] = disp_req_i.dest_areg;
				r_new[tail] = new_tag;
				r_old[tail] = map_m[disp_req_i.dest_areg];	// 31 for a zero-reg dest
				r_dest[tail] = has_dest;
				r_done[tail] = 1'b0;
				if (has_dest) begin
					void'(free_m.pop_front());
					map_m[disp_req_i.dest_areg] = new_tag;
					rdy_m[new_tag] = 1'b0;
				end
				rob_cnt++;
			end
			if (exp_ret) begin
				if (r_dest[rob_head]) begin
					free_m.push_back(r_old[rob_head]);	// usable from next cycle
				end
				rob_head = (rob_head + 1) % ROB_DEPTH;
				rob_cnt--;
			end
		end else if (cur_test != 0) begin
			close_test();	// table ran out
			cur_test = 0;
		end
	end

endmodule : rename_checker

//--- tb/rename_core_tb.sv
// table-driven run of the rename core; rows must keep completions legal, table holds at most 64 rows
module rename_core_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import rename_pkg::*;

	typedef struct packed {
		logic [2:0]	test;
		disp_req_t	disp;
		complete_t	comp;
		logic		acc;	// expected accept
		logic		ret;	// expected retire valid
	} row_t;

	row_t			rows [64];
	int				n_rows = 0;
	int				cycles = 0;
	logic			clk;
	logic			rst_n;
	disp_req_t		disp_req;
	complete_t		complete;
	logic			check_en;
	int				test_id;
	logic			exp_acc;
	logic			exp_ret;
	logic			disp_accept;
	rename_rsp_t	rename_rsp;
	retire_t		retire;
	int				tests_ok;
	int				tests_bad;
	int				errors;

	rename_core UUT (
		.clk			(clk),
		.rst_n_i		(rst_n),
		.disp_req_i		(disp_req),
		.complete_i		(complete),
		.disp_accept_o	(disp_accept),
		.rename_o		(rename_rsp),
		.retire_o		(retire)
	);

	rename_checker checker0 (
		.clk			(clk),
		.rst_n_i		(rst_n),
		.check_en_i		(check_en),
		.test_i			(test_id),
		.exp_accept_i	(exp_acc),
		.exp_retire_i	(exp_ret),
		.disp_req_i		(disp_req),
		.complete_i		(complete),
		.accept_i		(disp_accept),
		.rename_i		(rename_rsp),
		.retire_i		(retire),
		.tests_ok_o		(tests_ok),
		.tests_bad_o	(tests_bad),
		.errors_o		(errors)
	);

	always #5 clk = ~clk;	// 10 ns

	// ====================
	// stimulus table
	// ====================
	task automatic add_row(input int test, input logic dv, input int dest, input int opa,
		input int opb, input logic cv, input int cidx, input logic acc, input logic ret);
		rows[n_rows] = {3'(test), dv, 5'(dest), 5'(opa), 5'(opb), cv, 4'(cidx), acc, ret};
		n_rows++;
	endtask

	task automatic fill_table();
		// test, valid, dest, opa, opb, cmp valid, cmp idx, accept, retire
		add_row(1, 1, 1, 2, 3, 0, 0, 1, 0);		// tag 32, slot 0
		add_row(1, 1, 4, 5, 31, 0, 0, 1, 0);	// tag 33, slot 1
		add_row(2, 1, 6, 1, 4, 0, 0, 1, 0);		// reads 32 and 33, both pending
		add_row(2, 1, 7, 1, 2, 1, 0, 1, 0);		// slot 0 completes, still not ready
		add_row(2, 1, 8, 1, 4, 0, 0, 1, 1);		// 32 ready now, slot 0 retires
		// out of order completions 3,2,1,4
		add_row(3, 0, 0, 0, 0, 1, 3, 0, 0);
		add_row(3, 0, 0, 0, 0, 1, 2, 0, 0);
		add_row(3, 0, 0, 0, 0, 1, 1, 0, 0);
		add_row(3, 0, 0, 0, 0, 1, 4, 0, 1);
		add_row(3, 0, 0, 0, 0, 0, 0, 0, 1);
		add_row(3, 0, 0, 0, 0, 0, 0, 0, 1);
		add_row(3, 0, 0, 0, 0, 0, 0, 0, 1);
		for (int i = 0; i < 8; i++) begin
			add_row(4, 1, 10 + i, i, 31, 0, 0, 1, 0);	// 37,38,39 then freed 1,4,6,7,8
		end
		add_row(4, 1, 20, 0, 0, 0, 0, 0, 0);	// no tag left
		add_row(4, 1, 31, 10, 11, 0, 0, 1, 0);	// zero-reg dest needs none
		for (int i = 0; i < 7; i++) begin
			add_row(5, 1, 31, i, i + 1, 0, 0, 1, 0);	// ROB up to sixteen
		end
		add_row(5, 1, 31, 0, 0, 0, 0, 0, 0);	// full
		add_row(5, 1, 31, 0, 0, 1, 5, 0, 0);	// head completes
		add_row(5, 1, 31, 0, 0, 0, 0, 0, 1);	// head retires, full this cycle
		add_row(5, 1, 31, 0, 0, 0, 0, 1, 0);	// room again
		for (int i = 0; i < 8; i++) begin
			add_row(6, 0, 0, 0, 0, 1, 6 + i, 0, i != 0);	// slot 13 has no dest
		end
		add_row(6, 0, 0, 0, 0, 0, 0, 0, 1);		// retire with has_dest low, no push
		add_row(6, 1, 5, 10, 31, 0, 0, 1, 0);	// free head still tag 10
	endtask

	task automatic apply_row(input row_t r);
		disp_req	= r.disp;
		complete	= r.comp;
		exp_acc		= r.acc;
		exp_ret		= r.ret;
		test_id		= r.test;
		check_en	= 1'b1;
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		disp_req = '0;
		complete = '0;
		check_en = 1'b0;
		test_id = 0;
		exp_acc = 1'b0;
		exp_ret = 1'b0;
		fill_table();
		repeat (8) @(posedge clk);
		#1 rst_n = 1'b1;
		for (int r = 0; r < n_rows; r++) begin
			@(posedge clk);
			#1;
			apply_row(rows[r]);	// one row per cycle, 1 ns after the edge
		end
		@(posedge clk);
		#1;
		disp_req = '0;
		complete = '0;
		check_en = 1'b0;
		@(posedge clk);	// checker closes the last test here
		#1;
		$display("tests: %0d ok, %0d failed, %0d mismatches", tests_ok, tests_bad, errors);
		if (tests_ok == 6 && tests_bad == 0 && errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// run limit, table length plus slack for reset and drain
	always @(posedge clk) begin
		cycles++;
		if (cycles >= n_rows + 50) begin
			$display("timeout: run did not finish within %0d cycles", n_rows + 50);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

endmodule : rename_core_tb

//--- rename_core.f
rtl/rename_pkg.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/reorder_buffer.sv
rtl/rename_core.sv
tb/rename_checker.sv
tb/rename_core_tb.sv

//--- Bender.yml
package:
  name: rename_core

sources:
  - files:
      - rtl/rename_pkg.sv
      - rtl/map_table.sv
      - rtl/free_list.sv
      - rtl/reorder_buffer.sv
      - rtl/rename_core.sv
  - target: test
    files:
      - tb/rename_checker.sv
      - tb/rename_core_tb.sv
